// ==== design/spatz_core.sv ====
// Top of the vector slice: decode, decode slice, execute, execute slice, writeback
// Request and result channels are valid/ready
`timescale 1ns/10ps

module spatz_core (
        input  logic                    clk_i,
        input  logic                    rst_i,
        input  logic                    req_valid_i,
        input  spatz_pkg::decoder_req_t req_i,
        output logic                    req_ready_o,
        output logic                    result_valid_o,
        output spatz_pkg::result_t      result_o,
        input  logic                    result_ready_i
);
        import spatz_pkg::*;

        spatz_req_t dec_req;
        spatz_req_t exe_req;
        logic exe_valid;
        logic exe_ready;
        exec_rsp_t exe_rsp;
        exec_rsp_t wb_rsp;
        logic wb_valid;
        logic wb_ready;
        vrf_wr_t vrf_wr;
        vreg_t vs1_addr;
        vreg_t vs2_addr;
        vreg_t vd_addr;
        vec_t vs1_data;
        vec_t vs2_data;
        vec_t vd_data;

        spatz_decoder i_decoder (
                .req_i (req_i),
                .dec_o (dec_req)
        );

        spatz_pipe_reg #(
                .payload_t (spatz_req_t)
        ) i_dec_slice (
                .clk_i   (clk_i),
                .rst_i   (rst_i),
                .valid_i (req_valid_i),
                .ready_o (req_ready_o),
                .data_i  (dec_req),
                .valid_o (exe_valid),
                .ready_i (exe_ready),
                .data_o  (exe_req)
        );

        spatz_vrf i_vrf (
                .clk_i       (clk_i),
                .rst_i       (rst_i),
                .rd_addr_a_i (vs1_addr),
                .rd_addr_b_i (vs2_addr),
                .rd_addr_d_i (vd_addr),
                .wr_i        (vrf_wr),
                .rd_data_a_o (vs1_data),
                .rd_data_b_o (vs2_data),
                .rd_data_d_o (vd_data)
        );

        spatz_vfu i_vfu (
                .req_i      (exe_req),
                .vs1_data_i (vs1_data),
                .vs2_data_i (vs2_data),
                .vd_data_i  (vd_data),
                .vs1_addr_o (vs1_addr),
                .vs2_addr_o (vs2_addr),
                .vd_addr_o  (vd_addr),
                .rsp_o      (exe_rsp)
        );

        spatz_pipe_reg #(
                .payload_t (exec_rsp_t)
        ) i_exe_slice (
                .clk_i   (clk_i),
                .rst_i   (rst_i),
                .valid_i (exe_valid),
                .ready_o (exe_ready),
                .data_i  (exe_rsp),
                .valid_o (wb_valid),
                .ready_i (wb_ready),
                .data_o  (wb_rsp)
        );

        spatz_writeback i_writeback (
                .clk_i          (clk_i),
                .rst_i          (rst_i),
                .rsp_i          (wb_rsp),
                .rsp_valid_i    (wb_valid),
                .rsp_ready_o    (wb_ready),
                .result_o       (result_o),
                .result_valid_o (result_valid_o),
                .result_ready_i (result_ready_i),
                .vrf_wr_o       (vrf_wr)
        );

endmodule

// ==== design/spatz_decoder.sv ====
// Decode stage, purely combinational
// Maps an offloaded instruction word onto a spatz_req_t
`timescale 1ns/10ps

module spatz_decoder (
        input  spatz_pkg::decoder_req_t req_i,
        output spatz_pkg::spatz_req_t   dec_o
);
        import spatz_pkg::*;

        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [5:0] funct6;
        logic vm;
        vreg_t f_rd;
        vreg_t f_rs1;
        vreg_t f_rs2;
        logic [10:0] vtype;
        logic vtype_ok;
        logic is_shift;
        logic form_ok;
        logic illegal;
        spatz_req_t dec;

        assign opcode = req_i.instr[6:0];
        assign f_rd   = req_i.instr[11:7];
        assign funct3 = req_i.instr[14:12];
        assign f_rs1  = req_i.instr[19:15];
        assign f_rs2  = req_i.instr[24:20];
        assign vm     = req_i.instr[25];
        assign funct6 = req_i.instr[31:26];

        // vsetivli has a 10-bit zimm, vsetvli an 11-bit one
        assign vtype    = req_i.instr[31] ? {1'b0, req_i.instr[29:20]} : req_i.instr[30:20];
        // SEW=32 and LMUL=1 only
        assign vtype_ok = vtype[5:3] == 3'b010 && vtype[2:0] == 3'b000;
        assign is_shift = funct6 inside {F6_VSLL, F6_VSRL, F6_VSRA};

        ////////////////////
        // Decoder
        ////////////////////

        always_comb begin
                dec     = '0;
                dec.op  = VNOP;
                form_ok = 1'b1;
                illegal = 1'b1;

                if (opcode == OPC_V && funct3 == OPCFG) begin
                        dec.op = VCFG;
                        dec.rd = f_rd;
                        if (!req_i.instr[31]) begin
                                // vsetvli
                                dec.avl     = req_i.rs1;
                                dec.max_vl  = f_rs1 == '0 && f_rd != '0;
                                dec.keep_vl = f_rs1 == '0 && f_rd == '0;
                                illegal     = ~req_i.rs1_valid | ~vtype_ok;
                        end else if (req_i.instr[30]) begin
                                // vsetivli
                                dec.avl = elen_t'(f_rs1);
                                illegal = ~vtype_ok;
                        end
                end else if (opcode == OPC_V && funct3 inside {OPIVV, OPIVX, OPIVI}) begin
                        dec.vd      = f_rd;
                        dec.vs1     = f_rs1;
                        dec.vs2     = f_rs2;
                        dec.use_vs1 = funct3 == OPIVV;

                        unique case (funct6)
                                F6_VADD:  dec.op = VADD;
                                F6_VSUB:  dec.op = VSUB;
                                F6_VRSUB: dec.op = VRSUB;
                                F6_VAND:  dec.op = VAND;
                                F6_VOR:   dec.op = VOR;
                                F6_VXOR:  dec.op = VXOR;
                                F6_VSLL:  dec.op = VSLL;
                                F6_VSRL:  dec.op = VSRL;
                                F6_VSRA:  dec.op = VSRA;
                                F6_VMIN:  dec.op = VMIN;
                                F6_VMINU: dec.op = VMINU;
                                F6_VMAX:  dec.op = VMAX;
                                F6_VMAXU: dec.op = VMAXU;
                                default:  form_ok = 1'b0;
                        endcase

                        // Forms that RVV leaves undefined
                        if (funct3 == OPIVV && funct6 == F6_VRSUB) begin
                                form_ok = 1'b0;
                        end
                        if (funct3 == OPIVI && funct6 inside
                            {F6_VSUB, F6_VMIN, F6_VMINU, F6_VMAX, F6_VMAXU}) begin
                                form_ok = 1'b0;
                        end

                        if (funct3 == OPIVX) begin
                                dec.scalar = req_i.rs1;
                        end else if (is_shift) begin
                                dec.scalar = elen_t'(f_rs1);
                        end else begin
                                dec.scalar = elen_t'(signed'(f_rs1));
                        end

                        illegal = ~form_ok | ~vm | (funct3 == OPIVX && !req_i.rs1_valid);
                end

                if (illegal) begin
                        dec         = '0;
                        dec.op      = VNOP;
                        dec.illegal = 1'b1;
                end
        end

        assign dec_o = dec;

endmodule

// ==== design/spatz_pipe_reg.sv ====
// Single-entry register slice on a valid/ready channel
// Payload type is chosen per instance
`timescale 1ns/10ps

module spatz_pipe_reg #(
        parameter type payload_t = logic
) (
        input  logic     clk_i,
        input  logic     rst_i,
        input  logic     valid_i,
        output logic     ready_o,
        input  payload_t data_i,
        output logic     valid_o,
        input  logic     ready_i,
        output payload_t data_o
);

        logic valid_q;
        payload_t data_q;

        // Accept when empty or when the held item leaves this cycle
        assign ready_o = ~valid_q | ready_i;

        always_ff @(posedge clk_i) begin
                if (rst_i) begin
                        valid_q <= 1'b0;
                end else if (ready_o) begin
                        valid_q <= valid_i;
                end
        end

        always_ff @(posedge clk_i) begin
                if (ready_o) begin
                        data_q <= data_i;
                end
        end

        assign valid_o = valid_q;
        assign data_o  = data_q;

endmodule

// ==== design/spatz_pkg.sv ====
// Constants, encodings and packed payload types of the vector slice
// Compiled ahead of every other design file
package spatz_pkg;

        ////////////////////
        // Sizes
        ////////////////////

        localparam int unsigned ELEN     = 32;
        localparam int unsigned NR_LANES = 4;
        localparam int unsigned NR_VREGS = 32;
        localparam int unsigned VL_W     = $clog2(NR_LANES + 1);

        // OP-V major opcode and funct3 categories
        localparam logic [6:0] OPC_V = 7'b1010111;
        localparam logic [2:0] OPIVV = 3'b000;
        localparam logic [2:0] OPIVI = 3'b011;
        localparam logic [2:0] OPIVX = 3'b100;
        localparam logic [2:0] OPCFG = 3'b111;

        // funct6 of the integer ops
        localparam logic [5:0] F6_VADD  = 6'b000000;
        localparam logic [5:0] F6_VSUB  = 6'b000010;
        localparam logic [5:0] F6_VRSUB = 6'b000011;
        localparam logic [5:0] F6_VMINU = 6'b000100;
        localparam logic [5:0] F6_VMIN  = 6'b000101;
        localparam logic [5:0] F6_VMAXU = 6'b000110;
        localparam logic [5:0] F6_VMAX  = 6'b000111;
        localparam logic [5:0] F6_VAND  = 6'b001001;
        localparam logic [5:0] F6_VOR   = 6'b001010;
        localparam logic [5:0] F6_VXOR  = 6'b001011;
        localparam logic [5:0] F6_VSLL  = 6'b100101;
        localparam logic [5:0] F6_VSRL  = 6'b101000;
        localparam logic [5:0] F6_VSRA  = 6'b101001;

        ////////////////////
        // Types
        ////////////////////

        typedef logic [ELEN-1:0] elen_t;
        typedef logic [4:0] vreg_t;
        typedef elen_t [NR_LANES-1:0] vec_t;
        typedef logic [VL_W-1:0] vl_t;

        typedef enum logic [3:0] {
                VADD, VSUB, VRSUB, VAND, VOR, VXOR, VSLL, VSRL, VSRA,
                VMIN, VMINU, VMAX, VMAXU, VCFG, VNOP
        } op_e;

        typedef struct packed {
                logic [31:0] instr;
                elen_t       rs1;
                logic        rs1_valid;
        } decoder_req_t;

        typedef struct packed {
                op_e   op;
                vreg_t vd;
                vreg_t vs1;
                vreg_t vs2;
                logic  use_vs1;
                elen_t scalar;
                vreg_t rd;
                elen_t avl;
                logic  keep_vl;
                logic  max_vl;
                logic  illegal;
        } spatz_req_t;

        typedef struct packed {
                op_e   op;
                vreg_t vd;
                vreg_t rd;
                elen_t avl;
                logic  keep_vl;
                logic  max_vl;
                logic  illegal;
                vec_t  res;
                vec_t  old_vd;
        } exec_rsp_t;

        typedef struct packed {
                logic  illegal;
                logic  is_cfg;
                vreg_t vd;
                vreg_t rd;
                vl_t   vl;
                vec_t  data;
        } result_t;

        typedef struct packed {
                logic  en;
                vreg_t addr;
                vec_t  data;
        } vrf_wr_t;

endpackage

// ==== design/spatz_vfu.sv ====
// Execute stage, combinational over all lanes
// Reads its operands from the VRF and produces an exec_rsp_t
`timescale 1ns/10ps

module spatz_vfu (
        input  spatz_pkg::spatz_req_t req_i,
        input  spatz_pkg::vec_t       vs1_data_i,
        input  spatz_pkg::vec_t       vs2_data_i,
        input  spatz_pkg::vec_t       vd_data_i,
        output spatz_pkg::vreg_t      vs1_addr_o,
        output spatz_pkg::vreg_t      vs2_addr_o,
        output spatz_pkg::vreg_t      vd_addr_o,
        output spatz_pkg::exec_rsp_t  rsp_o
);
        import spatz_pkg::*;

        vec_t opa;
        vec_t res;

        assign vs1_addr_o = req_i.vs1;
        assign vs2_addr_o = req_i.vs2;
        assign vd_addr_o  = req_i.vd;

        // Scalar broadcast for VX and VI
        assign opa = req_i.use_vs1 ? vs1_data_i : {NR_LANES{req_i.scalar}};

        always_comb begin
                for (int i = 0; i < NR_LANES; i++) begin
                        unique case (req_i.op)
                                VADD:  res[i] = vs2_data_i[i] + opa[i];
                                VSUB:  res[i] = vs2_data_i[i] - opa[i];
                                VRSUB: res[i] = opa[i] - vs2_data_i[i];
                                VAND:  res[i] = vs2_data_i[i] & opa[i];
                                VOR:   res[i] = vs2_data_i[i] | opa[i];
                                VXOR:  res[i] = vs2_data_i[i] ^ opa[i];
                                VSLL:  res[i] = vs2_data_i[i] << opa[i][4:0];
                                VSRL:  res[i] = vs2_data_i[i] >> opa[i][4:0];
                                VSRA:  res[i] = elen_t'($signed(vs2_data_i[i]) >>> opa[i][4:0]);
                                VMIN:  res[i] = ($signed(opa[i]) < $signed(vs2_data_i[i])) ?
                                                opa[i] : vs2_data_i[i];
                                VMINU: res[i] = (opa[i] < vs2_data_i[i]) ? opa[i] : vs2_data_i[i];
                                VMAX:  res[i] = ($signed(opa[i]) > $signed(vs2_data_i[i])) ?
                                                opa[i] : vs2_data_i[i];
                                VMAXU: res[i] = (opa[i] > vs2_data_i[i]) ? opa[i] : vs2_data_i[i];
                                default: res[i] = '0;
                        endcase
                end
        end

        always_comb begin
                rsp_o.op      = req_i.op;
                rsp_o.vd      = req_i.vd;
                rsp_o.rd      = req_i.rd;
                rsp_o.avl     = req_i.avl;
                rsp_o.keep_vl = req_i.keep_vl;
                rsp_o.max_vl  = req_i.max_vl;
                rsp_o.illegal = req_i.illegal;
                rsp_o.res     = res;
                // Old vd travels along for the tail merge
                rsp_o.old_vd  = vd_data_i;
        end

endmodule

// ==== design/spatz_vrf.sv ====
// Vector register file, three combinational read ports and one write port
// A read hitting the pending write returns the write data
`timescale 1ns/10ps

module spatz_vrf (
        input  logic                clk_i,
        input  logic                rst_i,
        input  spatz_pkg::vreg_t    rd_addr_a_i,
        input  spatz_pkg::vreg_t    rd_addr_b_i,
        input  spatz_pkg::vreg_t    rd_addr_d_i,
        input  spatz_pkg::vrf_wr_t  wr_i,
        output spatz_pkg::vec_t     rd_data_a_o,
        output spatz_pkg::vec_t     rd_data_b_o,
        output spatz_pkg::vec_t     rd_data_d_o
);
        import spatz_pkg::*;

        vec_t regs_q [NR_VREGS];

        always_ff @(posedge clk_i) begin
                if (rst_i) begin
                        for (int i = 0; i < NR_VREGS; i++) begin
                                regs_q[i] <= '0;
                        end
                end else if (wr_i.en) begin
                        regs_q[wr_i.addr] <= wr_i.data;
                end
        end

        // Write-through bypass
        assign rd_data_a_o = (wr_i.en && wr_i.addr == rd_addr_a_i) ?
                             wr_i.data : regs_q[rd_addr_a_i];
        assign rd_data_b_o = (wr_i.en && wr_i.addr == rd_addr_b_i) ?
                             wr_i.data : regs_q[rd_addr_b_i];
        assign rd_data_d_o = (wr_i.en && wr_i.addr == rd_addr_d_i) ?
                             wr_i.data : regs_q[rd_addr_d_i];

endmodule

// ==== design/spatz_writeback.sv ====
// Result stage, owns vl and commits to the VRF on the result handshake
// Tail lanes at or above vl keep the old content of vd
`timescale 1ns/10ps

module spatz_writeback (
        input  logic                 clk_i,
        input  logic                 rst_i,
        input  spatz_pkg::exec_rsp_t rsp_i,
        input  logic                 rsp_valid_i,
        output logic                 rsp_ready_o,
        output spatz_pkg::result_t   result_o,
        output logic                 result_valid_o,
        input  logic                 result_ready_i,
        output spatz_pkg::vrf_wr_t   vrf_wr_o
);
        import spatz_pkg::*;

        vl_t vl_q;
        vl_t cfg_vl;
        logic fire;
        logic is_cfg;
        logic is_vec;
        vec_t merged;

        assign fire   = rsp_valid_i & result_ready_i;
        assign is_cfg = !rsp_i.illegal && rsp_i.op == VCFG;
        assign is_vec = !rsp_i.illegal && rsp_i.op != VCFG;

        ////////////////////
        // vl handling
        ////////////////////

        always_comb begin
                if (rsp_i.keep_vl) begin
                        cfg_vl = vl_q;
                end else if (rsp_i.max_vl || rsp_i.avl > NR_LANES) begin
                        cfg_vl = vl_t'(NR_LANES);
                end else begin
                        cfg_vl = vl_t'(rsp_i.avl);
                end
        end

        always_ff @(posedge clk_i) begin
                if (rst_i) begin
                        vl_q <= '0;
                end else if (fire && is_cfg) begin
                        vl_q <= cfg_vl;
                end
        end

        always_comb begin
                for (int i = 0; i < NR_LANES; i++) begin
                        merged[i] = (i < int'(vl_q)) ? rsp_i.res[i] : rsp_i.old_vd[i];
                end
        end

        always_comb begin
                result_o         = '0;
                result_o.illegal = rsp_i.illegal;
                result_o.is_cfg  = is_cfg;
                result_o.vd      = rsp_i.vd;
                result_o.rd      = rsp_i.rd;
                result_o.vl      = is_cfg ? cfg_vl : vl_q;
                result_o.data    = is_vec ? merged : '0;
        end

        assign result_valid_o = rsp_valid_i;
        assign rsp_ready_o    = result_ready_i;

        assign vrf_wr_o.en   = fire & is_vec;
        assign vrf_wr_o.addr = rsp_i.vd;
        assign vrf_wr_o.data = merged;

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds the vector slice testbench with Verilator and runs it
# The exit status is nonzero when the simulation reports a failure
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
        --top-module spatz_tb \
        -f tb.f \
        -o spatz_sim

./obj_dir/spatz_sim

// ==== tb.f ====
design/spatz_pkg.sv
design/spatz_decoder.sv
design/spatz_pipe_reg.sv
design/spatz_vrf.sv
design/spatz_vfu.sv
design/spatz_writeback.sv
design/spatz_core.sv
+incdir+verification
verification/spatz_tb.sv

// ==== verification/spatz_ref.svh ====
// Reference model of the vector slice, included inside the testbench module
// Keeps a mirror register file and vl, returns the expected result per request
`ifndef SPATZ_REF_SVH
`define SPATZ_REF_SVH

vec_t mregs [NR_VREGS];
vl_t  mvl;

// One lane of an integer op, b is vs2 and a the first operand
function automatic elen_t lane_op(logic [5:0] f6, elen_t a, elen_t b);
        case (f6)
                6'b000000: return b + a;
                6'b000010: return b - a;
                6'b000011: return a - b;
                6'b001001: return b & a;
                6'b001010: return b | a;
                6'b001011: return b ^ a;
                6'b100101: return b << a[4:0];
                6'b101000: return b >> a[4:0];
                6'b101001: return elen_t'($signed(b) >>> a[4:0]);
                6'b000101: return ($signed(a) < $signed(b)) ? a : b;
                6'b000100: return (a < b) ? a : b;
                6'b000111: return ($signed(a) > $signed(b)) ? a : b;
                default:   return (a > b) ? a : b;
        endcase
endfunction

function automatic result_t ref_result(decoder_req_t rq);
        logic [31:0] w;
        logic [5:0] f6;
        logic [2:0] f3;
        logic [4:0] f_rd;
        logic [4:0] f_r1;
        logic [4:0] f_r2;
        logic [10:0] vt;
        logic ok;
        elen_t opnd;
        elen_t avl;
        vec_t merged;
        result_t r;

        w    = rq.instr;
        f6   = w[31:26];
        f3   = w[14:12];
        f_rd = w[11:7];
        f_r1 = w[19:15];
        f_r2 = w[24:20];
        r    = '0;
        r.vl = mvl;
        ok   = 1'b0;

        if (w[6:0] == 7'h57 && f3 == 3'b111) begin
                vt = w[31] ? {1'b0, w[29:20]} : w[30:20];
                ok = vt[5:0] == 6'b010000 && (!w[31] ? rq.rs1_valid : w[30]);
                avl = w[31] ? elen_t'(f_r1) : rq.rs1;
                if (ok) begin
                        if (!w[31] && f_r1 == 5'd0) begin
                                r.vl = (f_rd == 5'd0) ? mvl : vl_t'(NR_LANES);
                        end else begin
                                r.vl = (avl > NR_LANES) ? vl_t'(NR_LANES) : vl_t'(avl);
                        end
                        r.is_cfg = 1'b1;
                        r.rd     = f_rd;
                        mvl      = r.vl;
                end
        end else if (w[6:0] == 7'h57 && f3 inside {3'b000, 3'b011, 3'b100}) begin
                ok = w[25] && (f6 inside {6'b000000, 6'b000011, 6'b001001, 6'b001010,
                                          6'b001011, 6'b100101, 6'b101000, 6'b101001});
                // These forms exist for VV and VX only
                if (f6 inside {6'b000010, 6'b000100, 6'b000101, 6'b000110, 6'b000111}) begin
                        ok = w[25] && f3 != 3'b011;
                end
                if (f3 == 3'b000 && f6 == 6'b000011) begin
                        ok = 1'b0;
                end
                if (f3 == 3'b100 && !rq.rs1_valid) begin
                        ok = 1'b0;
                end
                if (f3 == 3'b100) begin
                        opnd = rq.rs1;
                end else if (f6[5]) begin
                        opnd = {27'd0, f_r1};
                end else begin
                        opnd = {{27{f_r1[4]}}, f_r1};
                end
                if (ok) begin
                        for (int i = 0; i < NR_LANES; i++) begin
                                if (i < int'(mvl)) begin
                                        merged[i] = lane_op(f6, (f3 == 3'b000) ?
                                                    mregs[f_r1][i] : opnd, mregs[f_r2][i]);
                                end else begin
                                        merged[i] = mregs[f_rd][i];
                                end
                        end
                        mregs[f_rd] = merged;
                        r.vd   = f_rd;
                        r.data = merged;
                end
        end

        r.illegal = ~ok;
        return r;
endfunction

`endif

// ==== verification/spatz_tb.sv ====
// Drives random and directed requests into the vector slice under random result
// back-pressure and checks each result against the included reference model
`timescale 1ns/10ps

module spatz_tb;
        import spatz_pkg::*;

        localparam int REPS    = 6;
        localparam int N_CFG   = 9;
        localparam int N_FILL  = 7 * NR_LANES * 2;
        localparam int N_SWEEP = 13 * 3 * REPS;
        localparam int N_TAIL  = 3 * 9;
        localparam int N_ILL   = 11;
        localparam int N_TOTAL = N_CFG + N_FILL + N_SWEEP + N_TAIL + N_ILL;
        localparam logic [10:0] VT_OK = 11'h010;

        typedef logic [ELEN*NR_LANES-1:0] wide_t;

        logic clk_i;
        logic rst_i;
        logic req_valid_i;
        decoder_req_t req_i;
        logic req_ready_o;
        logic result_valid_o;
        result_t result_o;
        logic result_ready_i;

        integer seed = 32'hd8e1;
        logic rdy_next;
        result_t exp_q [$];
        string name_q [$];
        result_t exp_r;
        string exp_name;
        int n_sent;

        `include "spatz_ref.svh"

        spatz_core dut0 (
                .clk_i          (clk_i),
                .rst_i          (rst_i),
                .req_valid_i    (req_valid_i),
                .req_i          (req_i),
                .req_ready_o    (req_ready_o),
                .result_valid_o (result_valid_o),
                .result_o       (result_o),
                .result_ready_i (result_ready_i)
        );

        initial clk_i = 1'b0;
        always #50 clk_i = ~clk_i;

        task automatic fail_now(string msg);
                $display("%s", msg);
                $display("sim failed");
                $fatal(1);
        endtask

        task automatic check_field(string nm, string field, wide_t exp, wide_t act);
                assert (exp == act) else begin
                        fail_now($sformatf("ERROR %s %s expected %0h actual %0h",
                                           nm, field, exp, act));
                end
        endtask

        function automatic elen_t rnd();
                rnd = $random(seed);
        endfunction

        function automatic logic [31:0] opi(logic [5:0] f6, logic [2:0] f3, vreg_t vd,
                                            vreg_t vs2, logic [4:0] s1, logic vm);
                return {f6, vm, vs2, s1, f3, vd, 7'h57};
        endfunction

        function automatic logic [31:0] vsetvli(vreg_t rd, logic [4:0] s1, logic [10:0] vt);
                return {1'b0, vt, s1, 3'b111, rd, 7'h57};
        endfunction

        function automatic logic [31:0] vsetivli(vreg_t rd, logic [4:0] uimm, logic [9:0] vt);
                return {2'b11, vt, uimm, 3'b111, rd, 7'h57};
        endfunction

        function automatic logic [5:0] f6_of(int k);
                case (k)
                        0:  return 6'b000000;
                        1:  return 6'b000010;
                        2:  return 6'b000011;
                        3:  return 6'b001001;
                        4:  return 6'b001010;
                        5:  return 6'b001011;
                        6:  return 6'b100101;
                        7:  return 6'b101000;
                        8:  return 6'b101001;
                        9:  return 6'b000101;
                        10: return 6'b000100;
                        11: return 6'b000111;
                        default: return 6'b000110;
                endcase
        endfunction

        // Holds the request until accepted, then records the expectation
        task automatic send(logic [31:0] instr, elen_t rs1, logic rs1_valid, string name);
                req_valid_i = 1'b1;
                req_i = '{instr: instr, rs1: rs1, rs1_valid: rs1_valid};
                @(posedge clk_i);
                while (!req_ready_o) @(posedge clk_i);
                exp_q.push_back(ref_result(req_i));
                name_q.push_back(name);
                n_sent++;
                #1;
                req_valid_i = 1'b0;
        endtask

        task automatic random_op(int k, int form, string tag);
                logic [2:0] f3;
                vreg_t vd;
                vreg_t vs2;
                logic [4:0] s1;
                f3  = (form == 0) ? 3'b000 : ((form == 1) ? 3'b100 : 3'b011);
                vd  = vreg_t'(rnd() & 7);
                vs2 = vreg_t'(rnd() & 7);
                // Immediates use all five bits so the extension shows
                s1  = (form == 2) ? 5'(rnd()) : 5'(rnd() & 7);
                send(opi(f6_of(k), f3, vd, vs2, s1, 1'b1), rnd(), 1'b1,
                     $sformatf("%s op%0d form%0d #%0d", tag, k, form, n_sent));
        endtask

        ////////////////////
        // Result side
        ////////////////////

        always begin
                @(posedge clk_i);
                rdy_next = rst_i | ((rnd() & 3) != 0);
                #1;
                result_ready_i = rdy_next;
        end

        always @(posedge clk_i) begin
                if (!rst_i && result_valid_o && result_ready_i) begin
                        assert (exp_q.size() != 0) else begin
                                fail_now("a result came out with no request outstanding");
                        end
                        exp_r = exp_q.pop_front();
                        exp_name = name_q.pop_front();
                        check_field(exp_name, "illegal", wide_t'(exp_r.illegal),
                                    wide_t'(result_o.illegal));
                        check_field(exp_name, "is_cfg", wide_t'(exp_r.is_cfg),
                                    wide_t'(result_o.is_cfg));
                        check_field(exp_name, "vd", wide_t'(exp_r.vd), wide_t'(result_o.vd));
                        check_field(exp_name, "rd", wide_t'(exp_r.rd), wide_t'(result_o.rd));
                        check_field(exp_name, "vl", wide_t'(exp_r.vl), wide_t'(result_o.vl));
                        check_field(exp_name, "data", wide_t'(exp_r.data),
                                    wide_t'(result_o.data));
                end
        end

        initial begin
                repeat (N_TOTAL * 20) @(posedge clk_i);
                fail_now("timeout, the slice stopped producing results");
        end

        ////////////////////
        // Stimulus
        ////////////////////

        initial begin
                rst_i = 1'b1;
                req_valid_i = 1'b0;
                req_i = '0;
                result_ready_i = 1'b1;
                n_sent = 0;
                mvl = '0;
                for (int i = 0; i < NR_VREGS; i++) begin
                        mregs[i] = '0;
                end
                repeat (5) @(posedge clk_i);
                #1;
                rst_i = 1'b0;

                // vl configuration
                send(vsetivli(5'd1, 5'd9, VT_OK[9:0]), '0, 1'b0, "vsetivli avl 9");
                send(vsetivli(5'd2, 5'd2, VT_OK[9:0]), '0, 1'b0, "vsetivli avl 2");
                send(vsetvli(5'd0, 5'd0, VT_OK), '0, 1'b1, "vsetvli keep");
                send(vsetvli(5'd3, 5'd5, VT_OK), 32'd4, 1'b1, "vsetvli avl 4");
                send(vsetvli(5'd3, 5'd5, VT_OK), 32'd3, 1'b1, "vsetvli avl 3");
                send(vsetvli(5'd4, 5'd6, 11'h0d0), 32'd100, 1'b1, "vsetvli avl 100");
                send(vsetivli(5'd5, 5'd0, VT_OK[9:0]), '0, 1'b0, "vsetivli avl 0");
                send(vsetvli(5'd7, 5'd0, VT_OK), '0, 1'b1, "vsetvli max");
                send(vsetivli(5'd1, 5'd4, VT_OK[9:0]), '0, 1'b0, "vsetivli avl 4");

                // Distinct lane values in v1..v7 by growing vl
                for (int r = 1; r < 8; r++) begin
                        for (int k = 1; k <= NR_LANES; k++) begin
                                send(vsetivli(5'd0, 5'(k), VT_OK[9:0]), '0, 1'b0, "fill vl");
                                send(opi(6'b000000, 3'b100, vreg_t'(r), vreg_t'(r), 5'd1, 1'b1),
                                     rnd(), 1'b1, "fill vadd.vx");
                        end
                end

                // Every op and form at full vl over a small register range
                for (int k = 0; k < 13; k++) begin
                        for (int form = 0; form < 3; form++) begin
                                for (int n = 0; n < REPS; n++) begin
                                        random_op(k, form, "sweep");
                                end
                        end
                end

                // Illegal requests
                send(opi(6'b000000, 3'b000, 5'd1, 5'd2, 5'd3, 1'b0), '0, 1'b0, "vm=0");
                send(vsetvli(5'd1, 5'd2, 11'h018), 32'd2, 1'b1, "vsetvli e64");
                send(vsetivli(5'd1, 5'd2, 10'h011), '0, 1'b0, "vsetivli m2");
                send(opi(6'b000000, 3'b100, 5'd1, 5'd2, 5'd3, 1'b1), rnd(), 1'b0, "vx no rs1");
                send(vsetvli(5'd1, 5'd2, VT_OK), 32'd1, 1'b0, "vsetvli no rs1");
                send(opi(6'b111111, 3'b000, 5'd1, 5'd2, 5'd3, 1'b1), '0, 1'b0, "funct6");
                send(opi(6'b000000, 3'b010, 5'd1, 5'd2, 5'd3, 1'b1), '0, 1'b0, "funct3");
                send({25'h1234, 7'h33}, '0, 1'b0, "opcode");
                send({2'b10, 10'h010, 5'd2, 3'b111, 5'd1, 7'h57}, '0, 1'b1, "vsetvl");
                send(opi(6'b000011, 3'b000, 5'd1, 5'd2, 5'd3, 1'b1), '0, 1'b0, "vrsub.vv");
                send(opi(6'b000101, 3'b011, 5'd1, 5'd2, 5'd3, 1'b1), '0, 1'b0, "vmin.vi");

                // Tail lanes above vl
                for (int v = 1; v < NR_LANES; v++) begin
                        send(vsetivli(5'd0, 5'(v), VT_OK[9:0]), '0, 1'b0, "tail vl");
                        for (int n = 0; n < 8; n++) begin
                                random_op(int'(rnd() % 13), int'(rnd() % 3), "tail");
                        end
                end

                while (exp_q.size() != 0) @(posedge clk_i);
                repeat (5) @(posedge clk_i);
                #1;
                if (!result_valid_o) begin
                        $display("sim passed");
                        $finish;
                end else begin
                        fail_now("a result is still pending after the last expected one");
                end
        end

endmodule
